// File: hw/demosaic.sv
`timescale 1ns/1ps
`default_nettype none

module demosaic
	import ispPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	windowIf.consumer win,
	output pixelT red,
	output pixelT green,
	output pixelT blue,
	output logic pixOutValid,
	output logic frameDone
);

	logic [8:0] sumLeftUp;
	logic [8:0] sumCurDiag;
	pixelT avgLeftUp;
	pixelT avgCurDiag;
	pixelT nextRed;
	pixelT nextGreen;
	pixelT nextBlue;

	// ####################
	// Green averages
	// ####################
	assign sumLeftUp = {1'b0, win.left} + {1'b0, win.up};
	assign sumCurDiag = {1'b0, win.cur} + {1'b0, win.upLeft};
	assign avgLeftUp = sumLeftUp[8:1];	// Halve, drop the LSB.
	assign avgCurDiag = sumCurDiag[8:1];

	// ####################
	// Nearest-neighbour select
	// ####################
	always_comb begin
		case (win.site)
			SITE_RED: begin
				nextRed = win.cur;
				nextGreen = avgLeftUp;
				nextBlue = win.upLeft;	// Diagonal.
			end
			SITE_BLUE: begin
				nextRed = win.upLeft;
				nextGreen = avgLeftUp;
				nextBlue = win.cur;
			end
			SITE_GREEN_R: begin
				nextRed = win.left;	// Red neighbour sits to the left.
				nextGreen = avgCurDiag;
				nextBlue = win.up;
			end
			SITE_GREEN_B: begin
				nextRed = win.up;
				nextGreen = avgCurDiag;
				nextBlue = win.left;
			end
		endcase
	end

	// Output register.
	always_ff @(posedge clk) begin
		if (win.valid) begin
			red <= nextRed;
			green <= nextGreen;
			blue <= nextBlue;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pixOutValid <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			pixOutValid <= win.valid;
			frameDone <= win.valid && win.last;	// With the last output pixel.
		end
	end

endmodule

`default_nettype wire

// File: hw/ispConfig.sv
`timescale 1ns/1ps
`default_nettype none
`include "isp_defines.svh"

module ispConfig
	import ispPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire regT paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire regT pwdata,
	input wire logic frameDone,
	output regT prdata,
	output logic pready,
	output logic pslverr,
	output logic enable,
	output patternT pattern
);

	logic setup;
	logic access;
	logic ctrlHit;
	logic statusHit;
	logic [15:0] frameCount;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign ctrlHit = (paddr == `REG_CTRL);
	assign statusHit = (paddr == `REG_STATUS);

	assign pready = 1'b1;	// No wait states.
	assign pslverr = access && !(ctrlHit || statusHit);

	// ####################
	// Control register
	// ####################
	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 1'b0;
			pattern <= PAT_RGGB;
		end else if (access && pwrite && ctrlHit) begin
			enable <= pwdata[0];
			pattern <= patternT'(pwdata[2:1]);
		end
	end

	// Wraps at 16 bits.
	always_ff @(posedge clk) begin
		if (reset) begin
			frameCount <= '0;
		end else if (frameDone) begin
			frameCount <= frameCount + 16'd1;
		end
	end

	// Read data is latched in setup so it is stable for the whole access phase.
	always_ff @(posedge clk) begin
		if (setup && !pwrite) begin
			if (ctrlHit) begin
				prdata <= {29'b0, pattern, enable};
			end else if (statusHit) begin
				prdata <= {16'b0, frameCount};
			end else begin
				prdata <= '0;	// Unmapped address.
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/ispPkg.sv
`default_nettype none

package ispPkg;

	// ####################
	// Data widths
	// ####################

	typedef logic [7:0] pixelT;	// Raw Bayer sample or one colour.
	typedef logic [11:0] coordT;	// Row or column index.
	typedef logic [1:0] patternT;	// Colour at (0,0), or per-site code.
	typedef logic [31:0] regT;	// APB data word.

	// Pattern after reset.
	localparam patternT PAT_RGGB = 2'd0;

	// Per-pixel site codes, i.e. pattern XOR {row[0], col[0]}.
	localparam patternT SITE_RED = 2'd0;
	localparam patternT SITE_GREEN_R = 2'd1;	// Green in a red row.
	localparam patternT SITE_GREEN_B = 2'd2;	// Green in a blue row.
	localparam patternT SITE_BLUE = 2'd3;

endpackage

`default_nettype wire

// File: hw/ispTop.sv
`timescale 1ns/1ps
`default_nettype none

module ispTop
	import ispPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire regT paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire regT pwdata,
	input wire pixelT pixIn,
	input wire logic pixInValid,
	output wire regT prdata,
	output wire logic pready,
	output wire logic pslverr,
	output wire pixelT red,
	output wire pixelT green,
	output wire pixelT blue,
	output wire logic pixOutValid,
	output wire logic frameEnd
);

	wire logic enable;
	wire patternT pattern;

	windowIf win ();	// Stage 1 to stage 2.

	ispConfig i_ispConfig (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.frameDone(frameEnd),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.enable(enable),
		.pattern(pattern)
	);

	lineBuffer i_lineBuffer (
		.clk(clk),
		.reset(reset),
		.pixIn(pixIn),
		.pixInValid(pixInValid),
		.enable(enable),
		.pattern(pattern),
		.win(win.producer)
	);

	demosaic i_demosaic (
		.clk(clk),
		.reset(reset),
		.win(win.consumer),
		.red(red),
		.green(green),
		.blue(blue),
		.pixOutValid(pixOutValid),
		.frameDone(frameEnd)
	);

endmodule

`default_nettype wire

// File: hw/isp_defines.svh
`ifndef ISP_DEFINES_SVH
`define ISP_DEFINES_SVH

// ####################
// Frame geometry
// ####################

// Pixels per row.
`define IMG_WIDTH 16

// Rows per frame.
`define IMG_HEIGHT 8

// ####################
// APB register map
// ####################

// Enable in bit 0, Bayer pattern in bits 2:1.
`define REG_CTRL 32'h0000_0000

// Frame count in bits 15:0.
`define REG_STATUS 32'h0000_0004

`endif

// File: hw/lineBuffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "isp_defines.svh"

module lineBuffer
	import ispPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire pixelT pixIn,
	input wire logic pixInValid,
	input wire logic enable,
	input wire patternT pattern,
	windowIf.producer win
);

	localparam int unsigned ADDR_BITS = $clog2(`IMG_WIDTH);
	localparam coordT LAST_COL = coordT'(`IMG_WIDTH - 1);
	localparam coordT LAST_ROW = coordT'(`IMG_HEIGHT - 1);

	pixelT rowMem [`IMG_WIDTH];	// Previous row, indexed by column.
	coordT col;
	coordT row;
	logic accept;
	logic firstRow;
	logic firstCol;
	logic [ADDR_BITS-1:0] memAddr;
	pixelT above;

	assign accept = pixInValid && enable;
	assign firstRow = (row == '0);
	assign firstCol = (col == '0);
	assign memAddr = col[ADDR_BITS-1:0];

	// Read before the write of this cycle lands.
	assign above = firstRow ? '0 : rowMem[memAddr];

	// ####################
	// Raster position
	// ####################
	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (col == LAST_COL) begin
				col <= '0;
				if (row == LAST_ROW) begin
					row <= '0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rowMem[memAddr] <= pixIn;
		end
	end

	// ####################
	// 2x2 window
	// ####################
	always_ff @(posedge clk) begin
		if (reset) begin
			win.valid <= 1'b0;
		end else begin
			win.valid <= accept;
		end
	end

	// cur and up still hold the previous pixel, so they shift into left and upLeft.
	always_ff @(posedge clk) begin
		if (accept) begin
			win.cur <= pixIn;
			win.up <= above;
			win.left <= firstCol ? '0 : win.cur;
			win.upLeft <= firstCol ? '0 : win.up;
			win.site <= pattern ^ patternT'({row[0], col[0]});
			win.last <= (col == LAST_COL) && (row == LAST_ROW);
		end
	end

endmodule

`default_nettype wire

// File: hw/windowIf.sv
`timescale 1ns/1ps
`default_nettype none

interface windowIf
	import ispPkg::*;
();

	logic valid;
	pixelT cur;
	pixelT left;
	pixelT up;
	pixelT upLeft;
	patternT site;	// Colour code of the cur position.
	logic last;	// Last pixel of the frame.

	modport producer (
		output valid, cur, left, up, upLeft, site, last
	);

	modport consumer (
		input valid, cur, left, up, upLeft, site, last
	);

endinterface

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the ISP testbench with Verilator, then judge the run from its log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module ispTb -f sim.f -o ispSim \
	&& ./obj_dir/ispSim 2>&1 | tee sim.log
if [ ! -s sim.log ] || grep -q "Testbench failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"

// File: sim.f
+incdir+hw
+incdir+sim
hw/ispPkg.sv
hw/windowIf.sv
hw/ispConfig.sv
hw/lineBuffer.sv
hw/demosaic.sv
hw/ispTop.sv
sim/ispTb.sv

// File: sim/ispRef.svh
`ifndef ISP_REF_SVH
`define ISP_REF_SVH

// ####################
// Reference demosaic model
// ####################

// Reads zero left of column 0 and above row 0.
function automatic pixelT pixelAt(input pixelT img [`IMG_HEIGHT][`IMG_WIDTH],
		input int x, input int y);
	if (x < 0 || y < 0) begin
		return '0;
	end
	return img[y][x];
endfunction

// Expected {red, green, blue} of pixel (x, y) for one Bayer pattern.
function automatic logic [23:0] expectedRgb(input pixelT img [`IMG_HEIGHT][`IMG_WIDTH],
		input int x, input int y, input patternT pat);
	pixelT here;
	pixelT west;
	pixelT north;
	pixelT diag;
	logic [8:0] sideAvg;
	logic [8:0] diagAvg;
	logic [1:0] colour;
	here = img[y][x];
	west = pixelAt(img, x - 1, y);
	north = pixelAt(img, x, y - 1);
	diag = pixelAt(img, x - 1, y - 1);
	sideAvg = ({1'b0, west} + {1'b0, north}) >> 1;	// Green from left and up.
	diagAvg = ({1'b0, here} + {1'b0, diag}) >> 1;	// Green at a green site.
	colour = pat ^ {y[0], x[0]};
	case (colour)
		2'd0: return {here, sideAvg[7:0], diag};	// Red site.
		2'd3: return {diag, sideAvg[7:0], here};	// Blue site.
		2'd1: return {west, diagAvg[7:0], north};	// Green in a red row.
		default: return {north, diagAvg[7:0], west};	// Green in a blue row.
	endcase
endfunction

`endif

// File: sim/ispTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "isp_defines.svh"

module ispTb
	import ispPkg::*;
();

	localparam int NUM_FRAMES = 5;
	localparam int TIMEOUT = 4 * NUM_FRAMES * `IMG_WIDTH * `IMG_HEIGHT + 200;

	logic clk;
	logic reset;
	regT paddr;
	logic psel;
	logic penable;
	logic pwrite;
	regT pwdata;
	pixelT pixIn;
	logic pixInValid;
	regT prdata;
	logic pready;
	logic pslverr;
	pixelT red;
	pixelT green;
	pixelT blue;
	logic pixOutValid;
	logic frameEnd;

	integer seed;
	int cycle = 0;
	logic enableShadow;	// Mirrors the DUT enable bit.
	pixelT frame [`IMG_HEIGHT][`IMG_WIDTH];
	logic [24:0] expQ [$];	// {last, red, green, blue}.
	int timeQ [$];	// Cycle at which each pixel was taken.
	logic [24:0] want;
	int sentAt;
	regT rdata;
	logic slvErr;

	`include "ispRef.svh"

	ispTop i_ispTop (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ####################
	// Helpers
	// ####################
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic checkValue(input string name, input regT got, input regT exp);
		if (got !== exp) begin
			abortRun($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Setup phase, then access phase.
	task automatic apbAccess(input logic write, input regT addr, input regT wdata);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		rdata = prdata;
		slvErr = pslverr;
		checkValue("pready", 32'(pready), 32'd1);
		if (write && addr == `REG_CTRL) begin
			enableShadow <= wdata[0];
		end
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic sendFrame(input patternT pat, input logic gaps);
		for (int y = 0; y < `IMG_HEIGHT; y++) begin
			for (int x = 0; x < `IMG_WIDTH; x++) begin
				frame[y][x] = pixelT'($random(seed));
			end
		end
		for (int y = 0; y < `IMG_HEIGHT; y++) begin
			for (int x = 0; x < `IMG_WIDTH; x++) begin
				while (gaps && !1'($random(seed))) begin
					@(posedge clk);
					pixInValid <= 1'b0;	// Idle cycle.
				end
				@(posedge clk);
				pixIn <= frame[y][x];
				pixInValid <= 1'b1;
				expQ.push_back({(x == `IMG_WIDTH - 1) && (y == `IMG_HEIGHT - 1),
					expectedRgb(frame, x, y, pat)});
			end
		end
		@(posedge clk);
		pixInValid <= 1'b0;
	endtask

	// ####################
	// Output compare
	// ####################
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > TIMEOUT) begin
			abortRun($sformatf("Timed out with %0d expected pixels missing.", expQ.size()));
		end
		if (pixInValid && enableShadow) begin
			timeQ.push_back(cycle);
		end
		if (pixOutValid) begin
			if (expQ.size() == 0) begin
				abortRun("An output pixel appeared with no input pixel taken for it.");
			end else begin
				want = expQ.pop_front();
				sentAt = timeQ.pop_front();
				checkValue("red", 32'(red), 32'(want[23:16]));
				checkValue("green", 32'(green), 32'(want[15:8]));
				checkValue("blue", 32'(blue), 32'(want[7:0]));
				checkValue("frameEnd", 32'(frameEnd), 32'(want[24]));
				checkValue("latency", cycle - sentAt, 32'd2);
			end
		end
	end

	// ####################
	// Stimulus
	// ####################
	initial begin
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		pixIn = '0;
		pixInValid = 1'b0;
		enableShadow = 1'b0;
		seed = 32'h0cdfde85;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// Status reads zero and a disabled pipe stays silent.
		apbAccess(1'b0, `REG_STATUS, '0);
		checkValue("prdata", rdata, '0);
		checkValue("pslverr", 32'(slvErr), 32'd0);
		repeat (6) begin
			@(posedge clk);
			pixIn <= pixelT'($random(seed));
			pixInValid <= 1'b1;
		end
		@(posedge clk);
		pixInValid <= 1'b0;
		repeat (4) @(posedge clk);

		for (int p = 0; p < 4; p++) begin
			apbAccess(1'b1, `REG_CTRL, {29'b0, 2'(p), 1'b1});
			sendFrame(patternT'(p), 1'b0);
		end
		sendFrame(patternT'(3), 1'b1);	// BGGR with gaps.
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);

		// Unmapped address must not touch the registers.
		apbAccess(1'b1, 32'h0000_0010, 32'h0000_0002);
		checkValue("pslverr", 32'(slvErr), 32'd1);
		apbAccess(1'b0, 32'h0000_0010, '0);
		checkValue("pslverr", 32'(slvErr), 32'd1);
		apbAccess(1'b0, `REG_CTRL, '0);
		checkValue("prdata", rdata, 32'h0000_0007);
		apbAccess(1'b0, `REG_STATUS, '0);
		checkValue("prdata", rdata, NUM_FRAMES);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
